//--- common/task_unit_pkg.sv
`default_nettype none

package task_unit_pkg;

   // Task fields
   typedef logic [31:0] ts_t;
   typedef logic [3:0]  ttype_t;

   typedef struct packed {
      ts_t         ts;
      ttype_t      ttype;
      logic [15:0] locale;
      logic [31:0] args;
   } task_t;

   // Tasks of this type go to the splitter instead of the commit queue
   localparam ttype_t TASK_TYPE_SPLITTER = 4'hf;

   // Operations accepted by task_queue
   typedef enum logic [2:0] {
      NOP,
      ENQ,
      DEQ_MIN,
      DEQ_MAX,
      REPLACE
   } queue_op_t;

   // Write-only configuration strobe
   typedef struct packed {
      logic        wr;
      logic [3:0]  addr;
      logic [31:0] data;
   } cfg_wr_t;

   // Configuration addresses
   localparam logic [3:0] CFG_SPILL_THRESHOLD = 4'h0;
   localparam logic [3:0] CFG_SPILL_SIZE      = 4'h1;
   localparam logic [3:0] CFG_START           = 4'h2;
   localparam logic [3:0] CFG_THROTTLE_MARGIN = 4'h3;

   // Reset values
   localparam logic [31:0] DEFAULT_SPILL_THRESHOLD = 32'd12;
   localparam logic [31:0] DEFAULT_SPILL_SIZE      = 32'd4;
   // Zero margin disables the throttle
   localparam ts_t         DEFAULT_THROTTLE_MARGIN = 32'd0;

endpackage

`default_nettype wire

//--- task_queue/task_queue.sv
`default_nettype none

module task_queue
   import task_unit_pkg::*;
#(
   parameter int DEPTH = 16
) (
   input  wire logic                       clk,
   input  wire logic                       rstn,
   input  wire queue_op_t                  op,
   input  wire task_t                      in_task,
   output task_t                           min_task,
   output task_t                           max_task,
   output logic [$clog2(DEPTH+1)-1:0]      count,
   output logic                            nonempty
);

   localparam int LEAVES = 1 << $clog2(DEPTH);
   localparam int IW     = $clog2(LEAVES);
   localparam int CW     = $clog2(DEPTH + 1);

   task_t            slots [DEPTH];
   logic [DEPTH-1:0] vld;

   // Tree nodes, heap numbered, leaves at LEAVES..2*LEAVES-1
   logic [IW-1:0] mn_idx [1:2*LEAVES-1];
   logic          mn_vld [1:2*LEAVES-1];
   ts_t           mn_ts  [1:2*LEAVES-1];
   logic [IW-1:0] mx_idx [1:2*LEAVES-1];
   logic          mx_vld [1:2*LEAVES-1];
   ts_t           mx_ts  [1:2*LEAVES-1];

   logic [IW-1:0] free_idx;
   logic          free_found;

   for (genvar l = 0; l < LEAVES; l++) begin : g_leaf
      assign mn_idx[LEAVES+l] = IW'(l);
      assign mx_idx[LEAVES+l] = IW'(l);
      if (l < DEPTH) begin : g_slot
         assign mn_vld[LEAVES+l] = vld[l];
         assign mn_ts[LEAVES+l]  = slots[l].ts;
         assign mx_vld[LEAVES+l] = vld[l];
         assign mx_ts[LEAVES+l]  = slots[l].ts;
      end else begin : g_pad
         assign mn_vld[LEAVES+l] = 1'b0;
         assign mn_ts[LEAVES+l]  = '0;
         assign mx_vld[LEAVES+l] = 1'b0;
         assign mx_ts[LEAVES+l]  = '0;
      end
   end

   for (genvar n = 1; n < LEAVES; n++) begin : g_node
      logic take_l_min;
      logic take_l_max;

      assign take_l_min = mn_vld[2*n] && (!mn_vld[2*n+1] || (mn_ts[2*n] <= mn_ts[2*n+1]));
      assign take_l_max = mx_vld[2*n] && (!mx_vld[2*n+1] || (mx_ts[2*n] >= mx_ts[2*n+1]));

      assign mn_vld[n] = mn_vld[2*n] || mn_vld[2*n+1];
      assign mn_idx[n] = take_l_min ? mn_idx[2*n] : mn_idx[2*n+1];
      assign mn_ts[n]  = take_l_min ? mn_ts[2*n]  : mn_ts[2*n+1];

      assign mx_vld[n] = mx_vld[2*n] || mx_vld[2*n+1];
      assign mx_idx[n] = take_l_max ? mx_idx[2*n] : mx_idx[2*n+1];
      assign mx_ts[n]  = take_l_max ? mx_ts[2*n]  : mx_ts[2*n+1];
   end

   // Lowest free slot and occupancy
   always_comb begin
      free_idx   = '0;
      free_found = 1'b0;
      count      = '0;
      for (int i = 0; i < DEPTH; i++) begin
         if (!vld[i] && !free_found) begin
            free_idx   = IW'(i);
            free_found = 1'b1;
         end
         count = count + CW'(vld[i]);
      end
   end

   assign nonempty = mn_vld[1];
   assign min_task = slots[mn_idx[1]];
   assign max_task = slots[mx_idx[1]];

   always_ff @(posedge clk) begin
      if (!rstn) begin
         vld <= '0;
      end else begin
         case (op)
            ENQ:     if (free_found) vld[free_idx] <= 1'b1;
            DEQ_MIN: if (nonempty) vld[mn_idx[1]] <= 1'b0;
            DEQ_MAX: if (nonempty) vld[mx_idx[1]] <= 1'b0;
            default: ;
         endcase
      end
   end

   // Replace keeps the min slot occupied and overwrites it
   always_ff @(posedge clk) begin
      if (op == ENQ && free_found) begin
         slots[free_idx] <= in_task;
      end else if (op == REPLACE && nonempty) begin
         slots[mn_idx[1]] <= in_task;
      end
   end

endmodule

`default_nettype wire

//--- verilog/enq_stage.sv
`default_nettype none

module enq_stage
   import task_unit_pkg::*;
(
   input  wire logic  clk,
   input  wire logic  rstn,
   input  wire logic  task_enq_valid,
   input  wire task_t task_enq_data,
   input  wire logic  coal_child_valid,
   input  wire task_t coal_child_data,
   input  wire logic  spill_busy,
   input  wire logic  hold_clear,
   output logic       task_enq_ready,
   output logic       coal_child_ready,
   output task_t      held_task,
   output logic       held_valid
);

   logic can_take;

   assign can_take = !held_valid && !spill_busy;

   // Children from the coalescer win over new tasks
   assign coal_child_ready = can_take && coal_child_valid;
   assign task_enq_ready   = can_take && task_enq_valid && !coal_child_valid;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         held_valid <= 1'b0;
      end else if (coal_child_ready || task_enq_ready) begin
         held_valid <= 1'b1;
      end else if (hold_clear) begin
         held_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (coal_child_ready) begin
         held_task <= coal_child_data;
      end else if (task_enq_ready) begin
         held_task <= task_enq_data;
      end
   end

endmodule

`default_nettype wire

//--- verilog/task_unit_ctrl.sv
`default_nettype none

module task_unit_ctrl
   import task_unit_pkg::*;
#(
   parameter int TQ_DEPTH    = 16,
   parameter int SPILL_DEPTH = 8
) (
   input  wire logic                             clk,
   input  wire logic                             rstn,
   input  wire cfg_wr_t                          cfg_wr,
   input  wire ts_t                              gvt,
   input  wire logic                             held_valid,
   input  wire task_t                            main_min,
   input  wire logic [$clog2(TQ_DEPTH+1)-1:0]    main_count,
   input  wire logic                             main_nonempty,
   input  wire logic [$clog2(SPILL_DEPTH+1)-1:0] spill_count,
   input  wire logic                             spill_nonempty,
   input  wire logic                             task_deq_ready,
   input  wire logic                             splitter_deq_ready,
   input  wire logic                             overflow_ready,
   output logic                                  hold_clear,
   output logic                                  spill_busy,
   output queue_op_t                             main_op,
   output queue_op_t                             spill_op,
   output logic                                  task_deq_valid,
   output logic                                  splitter_deq_valid,
   output logic                                  overflow_valid,
   output logic                                  full,
   output logic                                  almost_full,
   output logic                                  empty,
   output ts_t                                   lvt
);

   localparam int MCW = $clog2(TQ_DEPTH + 1);
   localparam int SCW = $clog2(SPILL_DEPTH + 1);

   logic [MCW-1:0] spill_threshold;
   logic [SCW-1:0] spill_size;
   logic           started;
   ts_t            throttle_margin;
   ts_t            throttle_ts;
   logic [SCW-1:0] spills_left;

   logic           spill_start;
   logic           is_splitter;
   logic           deq_hs;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         spill_threshold <= MCW'(DEFAULT_SPILL_THRESHOLD);
         spill_size      <= SCW'(DEFAULT_SPILL_SIZE);
         started         <= 1'b0;
         throttle_margin <= DEFAULT_THROTTLE_MARGIN;
      end else if (cfg_wr.wr) begin
         case (cfg_wr.addr)
            CFG_SPILL_THRESHOLD: spill_threshold <= cfg_wr.data[MCW-1:0];
            CFG_SPILL_SIZE:      spill_size      <= cfg_wr.data[SCW-1:0];
            CFG_START:           started         <= cfg_wr.data[0];
            CFG_THROTTLE_MARGIN: throttle_margin <= cfg_wr.data;
            default: ;
         endcase
      end
   end

   // Bound of all ones means no throttling
   always_ff @(posedge clk) begin
      if (!rstn) begin
         throttle_ts <= '1;
      end else if (throttle_margin == '0) begin
         throttle_ts <= '1;
      end else begin
         throttle_ts <= gvt + throttle_margin;
      end
   end

   // Spill needs room for the whole burst in the spill queue
   assign spill_busy  = (spills_left != '0);
   assign spill_start = !spill_busy && (main_count > spill_threshold) &&
                        ((SCW'(SPILL_DEPTH) - spill_count) >= spill_size);

   always_ff @(posedge clk) begin
      if (!rstn) begin
         spills_left <= '0;
      end else if (spill_start) begin
         spills_left <= spill_size;
      end else if (spill_busy) begin
         spills_left <= spills_left - 1'b1;
      end
   end

   // Head routing and dispatch gates
   assign is_splitter        = (main_min.ttype == TASK_TYPE_SPLITTER);
   assign task_deq_valid     = main_nonempty && !spill_busy && !is_splitter && started &&
                               (main_min.ts < throttle_ts);
   assign splitter_deq_valid = main_nonempty && !spill_busy && is_splitter;
   assign deq_hs             = (task_deq_valid && task_deq_ready) ||
                               (splitter_deq_valid && splitter_deq_ready);

   assign overflow_valid = spill_nonempty && !spill_busy;

   always_comb begin
      main_op  = NOP;
      spill_op = NOP;
      if (spill_busy) begin
         if (main_nonempty) begin
            main_op  = DEQ_MAX;
            spill_op = ENQ;
         end
      end else begin
         if (held_valid && deq_hs) begin
            main_op = REPLACE;
         end else if (held_valid && !full) begin
            main_op = ENQ;
         end else if (deq_hs) begin
            main_op = DEQ_MIN;
         end
         if (overflow_valid && overflow_ready) begin
            spill_op = DEQ_MIN;
         end
      end
   end

   assign hold_clear = (main_op == ENQ) || (main_op == REPLACE);

   assign empty       = (main_count == '0);
   assign full        = (main_count == MCW'(TQ_DEPTH));
   assign almost_full = (main_count > spill_threshold);
   assign lvt         = main_nonempty ? main_min.ts : '1;

endmodule

`default_nettype wire

//--- verilog/task_unit_top.sv
`default_nettype none

module task_unit_top
   import task_unit_pkg::*;
#(
   parameter int TQ_DEPTH    = 16,
   parameter int SPILL_DEPTH = 8
) (
   input  wire logic    clk,
   input  wire logic    rstn,

   input  wire logic    task_enq_valid,
   output logic         task_enq_ready,
   input  wire task_t   task_enq_data,

   input  wire logic    coal_child_valid,
   output logic         coal_child_ready,
   input  wire task_t   coal_child_data,

   output logic         task_deq_valid,
   input  wire logic    task_deq_ready,
   output task_t        task_deq_data,

   output logic         splitter_deq_valid,
   input  wire logic    splitter_deq_ready,
   output task_t        splitter_deq_data,

   output logic         overflow_valid,
   input  wire logic    overflow_ready,
   output task_t        overflow_data,

   input  wire cfg_wr_t cfg_wr,
   input  wire ts_t     gvt,

   output logic         full,
   output logic         almost_full,
   output logic         empty,
   output ts_t          lvt
);

   localparam int MCW = $clog2(TQ_DEPTH + 1);
   localparam int SCW = $clog2(SPILL_DEPTH + 1);

   task_t           held_task;
   logic            held_valid;
   logic            hold_clear;
   logic            spill_busy;

   queue_op_t       main_op;
   queue_op_t       spill_op;

   task_t           main_min;
   task_t           main_max;
   logic [MCW-1:0]  main_count;
   logic            main_nonempty;

   task_t           spill_min;
   logic [SCW-1:0]  spill_count;
   logic            spill_nonempty;

   enq_stage u_enq_stage (
      .clk              (clk),
      .rstn             (rstn),
      .task_enq_valid   (task_enq_valid),
      .task_enq_data    (task_enq_data),
      .coal_child_valid (coal_child_valid),
      .coal_child_data  (coal_child_data),
      .spill_busy       (spill_busy),
      .hold_clear       (hold_clear),
      .task_enq_ready   (task_enq_ready),
      .coal_child_ready (coal_child_ready),
      .held_task        (held_task),
      .held_valid       (held_valid)
   );

   task_unit_ctrl #(
      .TQ_DEPTH    (TQ_DEPTH),
      .SPILL_DEPTH (SPILL_DEPTH)
   ) u_task_unit_ctrl (
      .clk                (clk),
      .rstn               (rstn),
      .cfg_wr             (cfg_wr),
      .gvt                (gvt),
      .held_valid         (held_valid),
      .main_min           (main_min),
      .main_count         (main_count),
      .main_nonempty      (main_nonempty),
      .spill_count        (spill_count),
      .spill_nonempty     (spill_nonempty),
      .task_deq_ready     (task_deq_ready),
      .splitter_deq_ready (splitter_deq_ready),
      .overflow_ready     (overflow_ready),
      .hold_clear         (hold_clear),
      .spill_busy         (spill_busy),
      .main_op            (main_op),
      .spill_op           (spill_op),
      .task_deq_valid     (task_deq_valid),
      .splitter_deq_valid (splitter_deq_valid),
      .overflow_valid     (overflow_valid),
      .full               (full),
      .almost_full        (almost_full),
      .empty              (empty),
      .lvt                (lvt)
   );

   task_queue #(
      .DEPTH (TQ_DEPTH)
   ) u_main_queue (
      .clk      (clk),
      .rstn     (rstn),
      .op       (main_op),
      .in_task  (held_task),
      .min_task (main_min),
      .max_task (main_max),
      .count    (main_count),
      .nonempty (main_nonempty)
   );

   // Spilled tasks come off the top of the main queue
   task_queue #(
      .DEPTH (SPILL_DEPTH)
   ) u_spill_queue (
      .clk      (clk),
      .rstn     (rstn),
      .op       (spill_op),
      .in_task  (main_max),
      .min_task (spill_min),
      .max_task (),
      .count    (spill_count),
      .nonempty (spill_nonempty)
   );

   assign task_deq_data     = main_min;
   assign splitter_deq_data = main_min;
   assign overflow_data     = spill_min;

endmodule

`default_nettype wire

//--- bench/task_unit_checks.svh
`ifndef TASK_UNIT_CHECKS_SVH
`define TASK_UNIT_CHECKS_SVH

int mismatches = 0;
int failures   = 0;

// Reference state of the unit
task_t m_main [$];
task_t m_spill [$];
task_t m_held;
logic  m_held_vld   = 1'b0;
int    m_spill_left = 0;
int    m_threshold  = DEFAULT_SPILL_THRESHOLD;
int    m_spill_size = DEFAULT_SPILL_SIZE;
logic  m_started    = 1'b0;
ts_t   m_margin     = DEFAULT_THROTTLE_MARGIN;
ts_t   m_bound      = '1;

// Departures per accepted timestamp
int    left_count [ts_t];
logic  enq_taken   = 1'b0;
logic  child_taken = 1'b0;
logic  spill_phase = 1'b0;
int    ovf_count   = 0;
int    tdeq_count  = 0;
ts_t   last_ovf_ts = '0;

task automatic check_task(input string name, input task_t got, input task_t exp);
   if (got !== exp) begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      mismatches++;
   end
endtask

task automatic check_ts(input string name, input ts_t got, input ts_t exp);
   if (got !== exp) begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      mismatches++;
   end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
   if (got !== exp) begin
      $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
      mismatches++;
   end
endtask

function automatic int min_pos(task_t q [$]);
   int p;
   p = -1;
   for (int i = 0; i < q.size(); i++) begin
      if (p < 0 || q[i].ts < q[p].ts) p = i;
   end
   return p;
endfunction

function automatic int max_pos(task_t q [$]);
   int p;
   p = -1;
   for (int i = 0; i < q.size(); i++) begin
      if (p < 0 || q[i].ts > q[p].ts) p = i;
   end
   return p;
endfunction

task automatic note_accept(input task_t t);
   left_count[t.ts] = 0;
endtask

task automatic note_leave(input task_t t);
   if (!left_count.exists(t.ts)) begin
      $display("Task %h left at %0t but was never accepted", t.ts, $time);
      failures++;
   end else if (left_count[t.ts] != 0) begin
      $display("Task %h left a second time at %0t", t.ts, $time);
      failures++;
   end else begin
      left_count[t.ts] = 1;
   end
endtask

// Checks one cycle of DUT outputs, then advances the model over the next edge
task automatic model_cycle();
   int    hp;
   int    sp;
   int    mp;
   int    pre_size;
   task_t head;
   task_t ot;
   logic  busy;
   logic  exp_tdv;
   logic  exp_sdv;
   logic  exp_ovv;
   logic  exp_cr;
   logic  exp_er;
   logic  deq;
   logic  start_spill;
   ts_t   next_bound;
   hp   = min_pos(m_main);
   sp   = min_pos(m_spill);
   busy = (m_spill_left != 0);
   head = (hp >= 0) ? m_main[hp] : '0;
   exp_tdv = (hp >= 0) && !busy && (head.ttype != TASK_TYPE_SPLITTER) && m_started &&
             (head.ts < m_bound);
   exp_sdv = (hp >= 0) && !busy && (head.ttype == TASK_TYPE_SPLITTER);
   exp_ovv = (sp >= 0) && !busy;
   exp_cr  = !m_held_vld && !busy && coal_child_valid;
   exp_er  = !m_held_vld && !busy && task_enq_valid && !coal_child_valid;

   check_flag("task_deq_valid", task_deq_valid, exp_tdv);
   check_flag("splitter_deq_valid", splitter_deq_valid, exp_sdv);
   check_flag("overflow_valid", overflow_valid, exp_ovv);
   check_flag("coal_child_ready", coal_child_ready, exp_cr);
   check_flag("task_enq_ready", task_enq_ready, exp_er);
   check_flag("empty", empty, m_main.size() == 0);
   check_flag("full", full, m_main.size() == TQ_DEPTH);
   check_flag("almost_full", almost_full, m_main.size() > m_threshold);
   check_ts("lvt", lvt, (hp >= 0) ? head.ts : '1);
   if (exp_tdv) check_task("task_deq_data", task_deq_data, head);
   if (exp_sdv) check_task("splitter_deq_data", splitter_deq_data, head);
   if (exp_ovv) check_task("overflow_data", overflow_data, m_spill[sp]);

   deq = (exp_tdv && task_deq_ready) || (exp_sdv && splitter_deq_ready);

   // Departures as the DUT delivers them
   if (task_deq_valid && task_deq_ready) begin
      note_leave(task_deq_data);
      tdeq_count++;
   end
   if (splitter_deq_valid && splitter_deq_ready) note_leave(splitter_deq_data);

   if (overflow_valid && overflow_ready) begin
      ot = overflow_data;
      note_leave(ot);
      if (spill_phase) begin
         mp = max_pos(m_main);
         if (ovf_count > 0 && ot.ts <= last_ovf_ts) begin
            $display("Overflow task %h at %0t is out of timestamp order", ot.ts, $time);
            failures++;
         end
         if ((mp >= 0 && m_main[mp].ts > ot.ts) || (m_held_vld && m_held.ts > ot.ts)) begin
            $display("Overflow task %h at %0t is not later than the tasks left", ot.ts, $time);
            failures++;
         end
         last_ovf_ts = ot.ts;
         ovf_count++;
      end
   end

   // Queue side of the edge
   pre_size    = m_main.size();
   start_spill = !busy && (pre_size > m_threshold) &&
                 ((SPILL_DEPTH - m_spill.size()) >= m_spill_size);
   if (busy) begin
      if (pre_size > 0) begin
         mp = max_pos(m_main);
         m_spill.push_back(m_main[mp]);
         m_main.delete(mp);
      end
      m_spill_left--;
   end else begin
      if (deq) m_main.delete(hp);
      if (m_held_vld && (deq || pre_size < TQ_DEPTH)) begin
         m_main.push_back(m_held);
         m_held_vld = 1'b0;
      end
      if (exp_ovv && overflow_ready) m_spill.delete(sp);
      if (start_spill) m_spill_left = m_spill_size;
   end

   // Input side of the edge
   enq_taken   = exp_er;
   child_taken = exp_cr;
   if (exp_cr) begin
      m_held     = coal_child_data;
      m_held_vld = 1'b1;
      note_accept(coal_child_data);
   end else if (exp_er) begin
      m_held     = task_enq_data;
      m_held_vld = 1'b1;
      note_accept(task_enq_data);
   end

   next_bound = (m_margin == '0) ? '1 : gvt + m_margin;
   if (cfg_wr.wr) begin
      case (cfg_wr.addr)
         CFG_SPILL_THRESHOLD: m_threshold  = cfg_wr.data;
         CFG_SPILL_SIZE:      m_spill_size = cfg_wr.data;
         CFG_START:           m_started    = cfg_wr.data[0];
         CFG_THROTTLE_MARGIN: m_margin     = cfg_wr.data;
         default: ;
      endcase
   end
   m_bound = next_bound;
endtask

`endif

//--- bench/task_unit_tb.sv
`default_nettype none

module task_unit_tb
   import task_unit_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int TQ_DEPTH     = 16;
   localparam int SPILL_DEPTH  = 8;
   localparam int CLK_PERIOD   = 100;
   localparam int P1_CYCLES    = 40;
   localparam int P2_CYCLES    = 400;
   localparam int P4_CYCLES    = 60;
   localparam int FILL_CYCLES  = 120;
   localparam int P5_CYCLES    = 40;
   localparam int DRAIN_CYCLES = 300;
   localparam int STIM_CYCLES  = P1_CYCLES + P2_CYCLES + P4_CYCLES + FILL_CYCLES +
                                 P5_CYCLES + 4 * DRAIN_CYCLES;
   localparam int TIMEOUT_NS   = 2 * STIM_CYCLES * CLK_PERIOD;
   localparam ts_t MARGIN      = 32'h0080_0000;
   localparam int SPILL_BURST  = 3;

   logic    clk = 1'b0;
   logic    rstn;
   logic    task_enq_valid;
   task_t   task_enq_data;
   logic    task_enq_ready;
   logic    coal_child_valid;
   task_t   coal_child_data;
   logic    coal_child_ready;
   logic    task_deq_valid;
   logic    task_deq_ready;
   task_t   task_deq_data;
   logic    splitter_deq_valid;
   logic    splitter_deq_ready;
   task_t   splitter_deq_data;
   logic    overflow_valid;
   logic    overflow_ready;
   task_t   overflow_data;
   cfg_wr_t cfg_wr;
   ts_t     gvt;
   logic    full;
   logic    almost_full;
   logic    empty;
   ts_t     lvt;

   int seed         = 50;
   int serial       = 0;
   int issue_target = 0;
   int issued       = 0;
   int occ_limit    = 0;
   int deq_mode     = 0;
   int ovf_mode     = 0;

   `include "task_unit_checks.svh"

   always #(CLK_PERIOD / 2) clk = ~clk;

   task_unit_top #(
      .TQ_DEPTH    (TQ_DEPTH),
      .SPILL_DEPTH (SPILL_DEPTH)
   ) u_task_unit_top (
      .clk                (clk),
      .rstn               (rstn),
      .task_enq_valid     (task_enq_valid),
      .task_enq_ready     (task_enq_ready),
      .task_enq_data      (task_enq_data),
      .coal_child_valid   (coal_child_valid),
      .coal_child_ready   (coal_child_ready),
      .coal_child_data    (coal_child_data),
      .task_deq_valid     (task_deq_valid),
      .task_deq_ready     (task_deq_ready),
      .task_deq_data      (task_deq_data),
      .splitter_deq_valid (splitter_deq_valid),
      .splitter_deq_ready (splitter_deq_ready),
      .splitter_deq_data  (splitter_deq_data),
      .overflow_valid     (overflow_valid),
      .overflow_ready     (overflow_ready),
      .overflow_data      (overflow_data),
      .cfg_wr             (cfg_wr),
      .gvt                (gvt),
      .full               (full),
      .almost_full        (almost_full),
      .empty              (empty),
      .lvt                (lvt)
   );

   // Unique timestamps, the serial number sits in the low bits
   function automatic task_t new_task();
      task_t       t;
      logic [31:0] r;
      r        = $random(seed);
      serial   = serial + 1;
      t.ts     = {8'h00, r[11:0], serial[11:0]};
      t.ttype  = (r[13:12] == 2'b00) ? TASK_TYPE_SPLITTER : ttype_t'(r[17:14] % 15);
      t.locale = r[31:16];
      t.args   = $random(seed);
      return t;
   endfunction

   function automatic logic pick_ready(input int mode);
      logic [31:0] r;
      r = $random(seed);
      return (mode == 2) ? r[0] : (mode == 1);
   endfunction

   always @(posedge clk) begin : drive_inputs
      int avail;
      int room;
      avail = issue_target - issued;
      room  = occ_limit - (m_main.size() + int'(m_held_vld) +
                           int'(task_enq_valid && !enq_taken) +
                           int'(coal_child_valid && !child_taken));
      if (rstn) begin
         if (!coal_child_valid || child_taken) begin
            if (avail > 0 && room > 0 && ($random(seed) & 3) == 0) begin
               coal_child_valid <= 1'b1;
               coal_child_data  <= new_task();
               avail--;
               room--;
            end else begin
               coal_child_valid <= 1'b0;
            end
         end
         if (!task_enq_valid || enq_taken) begin
            if (avail > 0 && room > 0 && ($random(seed) & 1) == 0) begin
               task_enq_valid <= 1'b1;
               task_enq_data  <= new_task();
               avail--;
            end else begin
               task_enq_valid <= 1'b0;
            end
         end
         issued             <= issue_target - avail;
         task_deq_ready     <= pick_ready(deq_mode);
         splitter_deq_ready <= pick_ready(deq_mode);
         overflow_ready     <= pick_ready(ovf_mode);
      end
   end

   always @(negedge clk) begin
      if (rstn) model_cycle();
   end

   task automatic write_cfg(input logic [3:0] addr, input logic [31:0] data);
      @(posedge clk);
      cfg_wr <= '{wr: 1'b1, addr: addr, data: data};
      @(posedge clk);
      cfg_wr <= '0;
   endtask

   task automatic drain();
      @(posedge clk);
      deq_mode <= 1;
      ovf_mode <= 1;
      @(posedge clk);
      while (m_main.size() != 0 || m_spill.size() != 0 || m_held_vld ||
             issued != issue_target || task_enq_valid || coal_child_valid) begin
         @(posedge clk);
      end
   endtask

   initial begin
      rstn               = 1'b0;
      task_enq_valid     = 1'b0;
      task_enq_data      = '0;
      coal_child_valid   = 1'b0;
      coal_child_data    = '0;
      task_deq_ready     = 1'b0;
      splitter_deq_ready = 1'b0;
      overflow_ready     = 1'b0;
      cfg_wr             = '0;
      gvt                = '0;
      repeat (4) @(posedge clk);
      rstn <= 1'b1;

      // Nothing may reach the commit queue before start
      @(posedge clk);
      deq_mode     <= 1;
      ovf_mode     <= 1;
      occ_limit    <= 6;
      issue_target <= 10;
      repeat (P1_CYCLES) @(posedge clk);
      if (tdeq_count != 0) begin
         $display("A task left on task_deq before the start register was set");
         failures++;
      end

      // Random traffic below the spill threshold
      write_cfg(CFG_START, 32'd1);
      deq_mode     <= 2;
      occ_limit    <= 8;
      issue_target <= issue_target + 150;
      repeat (P2_CYCLES) @(posedge clk);
      drain();

      // Throttle against gvt plus margin
      write_cfg(CFG_THROTTLE_MARGIN, MARGIN);
      issue_target <= issue_target + 10;
      repeat (P4_CYCLES) @(posedge clk);
      if (m_main.size() == 0) begin
         $display("The throttle held back no task");
         failures++;
      end
      gvt <= 32'h0100_0000;
      drain();
      write_cfg(CFG_THROTTLE_MARGIN, 32'd0);

      // Fill to full with spilling off and the dequeue side blocked
      @(posedge clk);
      deq_mode <= 0;
      write_cfg(CFG_SPILL_THRESHOLD, TQ_DEPTH);
      occ_limit    <= TQ_DEPTH + 2;
      issue_target <= issue_target + TQ_DEPTH + 2;
      repeat (FILL_CYCLES) @(posedge clk);
      if (m_main.size() != TQ_DEPTH || !m_held_vld) begin
         $display("The queue did not fill up with a task waiting in front of it");
         failures++;
      end
      drain();

      // Spill burst with the dequeue side blocked
      @(posedge clk);
      deq_mode <= 0;
      ovf_mode <= 1;
      write_cfg(CFG_SPILL_THRESHOLD, 32'd4);
      write_cfg(CFG_SPILL_SIZE, SPILL_BURST);
      spill_phase  <= 1'b1;
      occ_limit    <= 5;
      issue_target <= issue_target + 5;
      repeat (P5_CYCLES) @(posedge clk);
      if (ovf_count != SPILL_BURST) begin
         $display("%0d tasks left on overflow, %0d were expected", ovf_count, SPILL_BURST);
         failures++;
      end
      spill_phase <= 1'b0;
      drain();

      foreach (left_count[k]) begin
         if (left_count[k] != 1) begin
            $display("Task %h was accepted but never left", k);
            failures++;
         end
      end

      $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
      if (mismatches == 0 && failures == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

   initial begin
      #(TIMEOUT_NS);
      $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
      $display("STATUS: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

//--- flist.f
+incdir+bench
common/task_unit_pkg.sv
task_queue/task_queue.sv
verilog/enq_stage.sv
verilog/task_unit_ctrl.sv
verilog/task_unit_top.sv
bench/task_unit_tb.sv
